// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --assert -j 0
LINT     = --lint-only --timing --assert
TOP      = matvec_tb
FILELIST = src.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS     = TEST PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) $(LINT) --top-module $(TOP) -f $(FILELIST)

build:
	$(TOOL) $(FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

# the log decides the result, an assertion stop leaves no pass line
sim: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS)" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hw/mac_unit.sv ====
// ----------------------------------------------------------------------
// multiply and saturating accumulate
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module mac_unit import matvec_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  data_t w_data,
    input  data_t x_data,
    input  logic  term_valid,
    input  logic  term_first,
    input  logic  term_last,
    input  logic  output_ready,
    output logic  output_valid,
    output acc_t  output_data,
    output logic  row_taken
);

    localparam int ACC_W = $bits(acc_t);
    localparam acc_t ACC_MAX = {1'b0, {(ACC_W-1){1'b1}}};
    localparam acc_t ACC_MIN = {1'b1, {(ACC_W-1){1'b0}}};

    acc_t product;
    acc_t acc_base;
    acc_t raw_sum;
    acc_t sat_sum;
    acc_t acc_q;
    acc_t result_q;

    // both operands are sign extended before the multiply
    assign product = acc_t'(w_data) * acc_t'(x_data);

    assign acc_base = term_first ? '0 : acc_q; // first column starts a fresh row
    assign raw_sum = acc_base + product;

    // overflow shows as a sum whose sign differs from two equal-signed operands
    always_comb begin
        sat_sum = raw_sum;
        if (!acc_base[ACC_W-1] && !product[ACC_W-1] && raw_sum[ACC_W-1]) begin
            sat_sum = ACC_MAX;
        end else if (acc_base[ACC_W-1] && product[ACC_W-1] && !raw_sum[ACC_W-1]) begin
            sat_sum = ACC_MIN;
        end
    end

    always_ff @(posedge clk) begin
        if (term_valid) begin
            acc_q <= sat_sum;
        end
        if (term_valid && term_last) begin
            result_q <= sat_sum; // held here until the consumer takes it
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            output_valid <= 1'b0;
        end else if (term_valid && term_last) begin
            output_valid <= 1'b1;
        end else if (row_taken) begin
            output_valid <= 1'b0;
        end
    end

    assign output_data = result_q;
    assign row_taken = output_valid && output_ready; // lets the sequencer move on after the take

endmodule

// ==== hw/matrix_store.sv ====
// ----------------------------------------------------------------------
// matrix word store
// ----------------------------------------------------------------------

`timescale 1ns/100ps

`include "matvec_config.svh"

module matrix_store import matvec_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  wr_en,
    input  data_t wr_data,
    input  logic  rd_en,
    input  idx_t  rd_row,
    input  idx_t  rd_col,
    output logic  last,
    output data_t rd_data
);

    localparam int SLOTS = `MATVEC_N * `MATVEC_N;
    localparam int ADDR_W = $clog2(SLOTS);
    localparam logic [ADDR_W-1:0] LAST_SLOT = ADDR_W'(SLOTS - 1);

    data_t             mem [SLOTS];
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_addr;

    // words arrive in row-major order, so the pointer is the flat index
    assign last = wr_en && (wr_ptr == LAST_SLOT);

    assign rd_addr = ADDR_W'(rd_row) * ADDR_W'(`MATVEC_N) + ADDR_W'(rd_col);

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= last ? '0 : wr_ptr + 1'b1; // wrap ready for the next reload
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== hw/matvec_config.svh ====
// ----------------------------------------------------------------------
// matrix-vector multiplier configuration
// ----------------------------------------------------------------------

`ifndef MATVEC_CONFIG_SVH
`define MATVEC_CONFIG_SVH

// matrix is MATVEC_N by MATVEC_N and the vector has MATVEC_N entries
`define MATVEC_N 3

// width of every signed word on the input stream
`define MATVEC_DATA_W 14

// products, running sums and results all share this width
// one full-scale product fits, but two or three of them can pass the limit,
// so rows of extreme inputs do reach the saturation logic
`define MATVEC_ACC_W 28

`endif

// ==== hw/matvec_pkg.sv ====
// ----------------------------------------------------------------------
// matrix-vector multiplier types
// ----------------------------------------------------------------------

`include "matvec_config.svh"

package matvec_pkg;

    // one signed word from the input stream, matrix or vector entry
    typedef logic signed [`MATVEC_DATA_W-1:0] data_t;

    // signed product, running sum and row result
    typedef logic signed [`MATVEC_ACC_W-1:0] acc_t;

    // row or column position inside the matrix
    typedef logic [$clog2(`MATVEC_N)-1:0] idx_t;

    // frame sequencing
    // a frame starts in S_FIRST, where new_matrix picks the load path,
    // and ends when the last row result has been taken
    typedef enum logic [2:0] {
        S_FIRST    = 3'd0, // idle until the first word of a frame
        S_LOAD_W   = 3'd1, // rest of the matrix words
        S_LOAD_X   = 3'd2, // vector words
        S_ISSUE    = 3'd3, // column reads for the current row
        S_WAIT_OUT = 3'd4  // row result waits for the consumer
    } seq_state_e;

endpackage

// ==== hw/matvec_sequencer.sv ====
// ----------------------------------------------------------------------
// frame sequencer
// ----------------------------------------------------------------------

`timescale 1ns/100ps

`include "matvec_config.svh"

module matvec_sequencer import matvec_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic input_valid,
    input  logic new_matrix,
    input  logic w_last,
    input  logic x_last,
    input  logic row_taken,
    output logic input_ready,
    output logic w_wr_en,
    output logic x_wr_en,
    output logic rd_en,
    output idx_t rd_row,
    output idx_t rd_col,
    output logic term_valid,
    output logic term_first,
    output logic term_last
);

    localparam idx_t LAST_IDX = idx_t'(`MATVEC_N - 1);

    seq_state_e state;
    seq_state_e state_next;
    idx_t       row_q;
    idx_t       col_q;
    logic       accept;
    logic       to_matrix;

    // the input side is open only while a frame is being loaded
    assign input_ready = (state == S_FIRST) || (state == S_LOAD_W) || (state == S_LOAD_X);
    assign accept = input_valid && input_ready;

    // new_matrix only matters on the first word of a frame
    assign to_matrix = (state == S_LOAD_W) || ((state == S_FIRST) && new_matrix);

    assign w_wr_en = accept && to_matrix;
    assign x_wr_en = accept && !to_matrix;

    assign rd_en = (state == S_ISSUE);
    assign rd_row = row_q;
    assign rd_col = col_q;

    always_comb begin
        state_next = state;
        case (state)
            S_FIRST, S_LOAD_W, S_LOAD_X: begin
                // the stores flag their final slot, so no word count is kept here
                if (w_wr_en) begin
                    state_next = w_last ? S_LOAD_X : S_LOAD_W;
                end else if (x_wr_en) begin
                    state_next = x_last ? S_ISSUE : S_LOAD_X;
                end
            end
            S_ISSUE: begin
                if (col_q == LAST_IDX) begin
                    state_next = S_WAIT_OUT;
                end
            end
            S_WAIT_OUT: begin
                // a stalled consumer keeps us here, one row in flight at most
                if (row_taken) begin
                    state_next = (row_q == LAST_IDX) ? S_FIRST : S_ISSUE;
                end
            end
            default: begin
                state_next = S_FIRST;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_FIRST;
        end else begin
            state <= state_next;
        end
    end

    // column steps once per read, row steps once per taken result
    always_ff @(posedge clk) begin
        if (reset) begin
            row_q <= '0;
            col_q <= '0;
        end else begin
            if (state == S_ISSUE) begin
                col_q <= (col_q == LAST_IDX) ? '0 : col_q + 1'b1;
            end
            if ((state == S_WAIT_OUT) && row_taken) begin
                row_q <= (row_q == LAST_IDX) ? '0 : row_q + 1'b1;
            end
        end
    end

    // read data is registered in the stores, so the term flags trail rd_en by one
    always_ff @(posedge clk) begin
        if (reset) begin
            term_valid <= 1'b0;
            term_first <= 1'b0;
            term_last  <= 1'b0;
        end else begin
            term_valid <= rd_en;
            term_first <= rd_en && (col_q == '0);
            term_last  <= rd_en && (col_q == LAST_IDX);
        end
    end

endmodule

// ==== hw/matvec_top.sv ====
// ----------------------------------------------------------------------
// streaming matrix-vector multiplier
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module matvec_top import matvec_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  input_valid,
    output logic  input_ready,
    input  data_t input_data,
    input  logic  new_matrix,
    output logic  output_valid,
    input  logic  output_ready,
    output acc_t  output_data
);

    logic  w_wr_en;
    logic  x_wr_en;
    logic  w_last;
    logic  x_last;
    logic  rd_en;
    idx_t  rd_row;
    idx_t  rd_col;
    data_t w_rd_data;
    data_t x_rd_data;
    logic  term_valid;
    logic  term_first;
    logic  term_last;
    logic  row_taken;

    matvec_sequencer i_sequencer (
        .clk         (clk),
        .reset       (reset),
        .input_valid (input_valid),
        .new_matrix  (new_matrix),
        .w_last      (w_last),
        .x_last      (x_last),
        .row_taken   (row_taken),
        .input_ready (input_ready),
        .w_wr_en     (w_wr_en),
        .x_wr_en     (x_wr_en),
        .rd_en       (rd_en),
        .rd_row      (rd_row),
        .rd_col      (rd_col),
        .term_valid  (term_valid),
        .term_first  (term_first),
        .term_last   (term_last)
    );

    // both stores see the input word, only the strobed one keeps it
    matrix_store i_matrix_store (
        .clk(clk), .reset(reset), .wr_en(w_wr_en), .wr_data(input_data), .rd_en(rd_en),
        .rd_row(rd_row), .rd_col(rd_col), .last(w_last), .rd_data(w_rd_data)
    );

    vector_store i_vector_store (
        .clk(clk), .reset(reset), .wr_en(x_wr_en), .wr_data(input_data), .rd_en(rd_en),
        .rd_col(rd_col), .last(x_last), .rd_data(x_rd_data)
    );

    mac_unit i_mac_unit (
        .clk(clk), .reset(reset), .w_data(w_rd_data), .x_data(x_rd_data),
        .term_valid(term_valid), .term_first(term_first), .term_last(term_last),
        .output_ready(output_ready), .output_valid(output_valid),
        .output_data(output_data), .row_taken(row_taken)
    );

endmodule

// ==== hw/vector_store.sv ====
// ----------------------------------------------------------------------
// vector word store
// ----------------------------------------------------------------------

`timescale 1ns/100ps

`include "matvec_config.svh"

module vector_store import matvec_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  wr_en,
    input  data_t wr_data,
    input  logic  rd_en,
    input  idx_t  rd_col,
    output logic  last,
    output data_t rd_data
);

    localparam idx_t LAST_SLOT = idx_t'(`MATVEC_N - 1);

    data_t mem [`MATVEC_N];
    idx_t  wr_ptr;

    assign last = wr_en && (wr_ptr == LAST_SLOT); // final vector word of the frame

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= last ? '0 : wr_ptr + 1'b1;
        end
    end

    // same entry is read once per row, the column index alone selects it
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
        if (rd_en) begin
            rd_data <= mem[rd_col];
        end
    end

endmodule

// ==== src.f ====
+incdir+hw
hw/matvec_pkg.sv
hw/matrix_store.sv
hw/vector_store.sv
hw/mac_unit.sv
hw/matvec_sequencer.sv
hw/matvec_top.sv
verif/matvec_sva.sv
verif/matvec_tb.sv

// ==== verif/matvec_sva.sv ====
// ----------------------------------------------------------------------
// matrix-vector multiplier assertions
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module matvec_sva import matvec_pkg::*; (
    input logic clk,
    input logic reset,
    input logic input_ready,
    input logic output_valid,
    input logic output_ready,
    input acc_t output_data
);

    // a stalled result keeps both its valid and its value
    hold_while_stalled: assert property (@(posedge clk) disable iff (reset)
        output_valid && !output_ready |=> output_valid && $stable(output_data))
    else $error("output word changed while the consumer stalled");

    load_or_deliver: assert property (@(posedge clk) disable iff (reset)
        !(input_ready && output_valid))
    else $error("input_ready and output_valid high together");

    // input_ready drops on the last vector word, row 0 shows up four cycles later
    first_row_latency: assert property (@(posedge clk) disable iff (reset)
        $fell(input_ready) |-> ##4 $rose(output_valid))
    else $error("first row result did not follow the last vector word in four cycles");

endmodule

bind matvec_top matvec_sva i_matvec_sva (
    .clk          (clk),
    .reset        (reset),
    .input_ready  (input_ready),
    .output_valid (output_valid),
    .output_ready (output_ready),
    .output_data  (output_data)
);

// ==== verif/matvec_tb.sv ====
// ----------------------------------------------------------------------
// matrix-vector multiplier testbench
// ----------------------------------------------------------------------

`timescale 1ns/100ps

`include "matvec_config.svh"

module matvec_tb import matvec_pkg::*; ();

    localparam int W_WORDS = `MATVEC_N * `MATVEC_N;
    localparam int X_WORDS = `MATVEC_N;
    localparam data_t DATA_MAX = {1'b0, {(`MATVEC_DATA_W-1){1'b1}}};
    localparam data_t DATA_MIN = {1'b1, {(`MATVEC_DATA_W-1){1'b0}}};

    // word patterns for a frame
    localparam int K_RANDOM = 0;
    localparam int K_MAX    = 1;
    localparam int K_MIN    = 2;
    localparam int K_MIXED  = 3; // matrix at the top, vector at the bottom

    logic  clk;
    logic  reset;
    logic  input_valid;
    logic  input_ready;
    data_t input_data;
    logic  new_matrix;
    logic  output_valid;
    logic  output_ready;
    acc_t  output_data;

    integer seed;
    data_t  model_w [W_WORDS];
    data_t  model_x [X_WORDS];
    acc_t   exp_q [$];
    int     checks;
    int     errors;
    int     tests;
    int     test_start_errors;
    int     taken_count;
    int     cycles;
    int     cycle_limit;
    int     gap_max;
    int     stall_max;
    int     stall_left;
    logic   rest;
    logic   hold_pending;
    acc_t   held_data;

    matvec_top i_matvec_top (
        .clk          (clk),
        .reset        (reset),
        .input_valid  (input_valid),
        .input_ready  (input_ready),
        .input_data   (input_data),
        .new_matrix   (new_matrix),
        .output_valid (output_valid),
        .output_ready (output_ready),
        .output_data  (output_data)
    );

    always #2 clk = ~clk;

    function automatic int rand_below(input int n);
        int unsigned r;
        r = $random(seed);
        return int'(r % n);
    endfunction

    function automatic data_t pick_word(input int kind, input logic is_w);
        case (kind)
            K_MAX:   return DATA_MAX;
            K_MIN:   return DATA_MIN;
            K_MIXED: return is_w ? DATA_MAX : DATA_MIN;
            default: return data_t'($random(seed));
        endcase
    endfunction

    // each partial sum is clamped to the accumulator range before the next term
    function automatic acc_t row_dot(input int r);
        longint acc_max;
        longint acc_min;
        longint s;
        int     c;
        acc_max = (longint'(1) <<< (`MATVEC_ACC_W - 1)) - 1;
        acc_min = -acc_max - 1;
        s = 0;
        for (c = 0; c < `MATVEC_N; c++) begin
            s = s + longint'(model_w[r * `MATVEC_N + c]) * longint'(model_x[c]);
            if (s > acc_max) begin
                s = acc_max;
            end else if (s < acc_min) begin
                s = acc_min;
            end
        end
        return acc_t'(s);
    endfunction

    // twelve words with their gaps, then three rows with pipeline and stall time
    function automatic int frame_cycles(input int gaps, input int stalls);
        return (W_WORDS + X_WORDS) * (gaps + 2) + `MATVEC_N * (stalls + 10);
    endfunction

    task automatic check_result(input string name, input acc_t got, input acc_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    // called on a falling edge, returns on the falling edge after the accept
    task automatic send_word(input data_t d, input logic nm);
        int gap;
        gap = rand_below(gap_max + 1);
        input_valid = 1'b0;
        input_data = data_t'($random(seed)); // junk while the bus is idle
        repeat (gap) @(negedge clk);
        input_valid = 1'b1;
        input_data = d;
        new_matrix = nm;
        while (!input_ready) @(negedge clk);
        @(negedge clk);
        input_valid = 1'b0;
    endtask

    task automatic run_frame(input logic load_w, input int kind);
        data_t words [$];
        int    i;
        int    target;
        if (load_w) begin
            for (i = 0; i < W_WORDS; i++) begin
                model_w[i] = pick_word(kind, 1'b1);
                words.push_back(model_w[i]);
            end
        end
        for (i = 0; i < X_WORDS; i++) begin
            model_x[i] = pick_word(kind, 1'b0);
            words.push_back(model_x[i]);
        end
        for (i = 0; i < `MATVEC_N; i++) begin
            exp_q.push_back(row_dot(i));
        end
        target = taken_count + `MATVEC_N;
        for (i = 0; i < words.size(); i++) begin
            send_word(words[i], (i == 0) ? load_w : (rand_below(2) == 1)); // noise after word 0
        end
        check_flag("input_ready after last word", input_ready, 1'b0);
        while (taken_count < target) begin
            check_flag("input_ready while rows pending", input_ready, 1'b0);
            @(negedge clk);
        end
        @(negedge clk);
        check_flag("input_ready after frame", input_ready, 1'b1);
    endtask

    task automatic finish_test(input string name);
        while ((exp_q.size() != 0) || output_valid) @(negedge clk);
        tests++;
        $display("test %0d, %s: %s", tests, name,
                 (errors == test_start_errors) ? "ok" : "errors seen");
        test_start_errors = errors;
    endtask

    // ready is chosen on the falling edge and each word is checked before it is taken
    always @(negedge clk) begin
        if (!reset) begin
            if (hold_pending) begin
                check_flag("output_valid while stalled", output_valid, 1'b1);
                check_result("output_data while stalled", output_data, held_data);
            end
            if (stall_left > 0) begin
                output_ready = 1'b0;
                stall_left = stall_left - 1;
            end else if (!rest && (stall_max > 0) && (rand_below(3) == 0)) begin
                output_ready = 1'b0;
                stall_left = rand_below(stall_max);
                rest = 1'b1; // one ready cycle follows every stall
            end else begin
                output_ready = 1'b1;
                rest = 1'b0;
            end
            hold_pending = output_valid && !output_ready;
            held_data = output_data;
            if (output_valid && output_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("result %0d arrived at %0t with no result expected",
                             output_data, $time);
                end else begin
                    check_result("output_data", output_data, exp_q.pop_front());
                end
                taken_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timed out after %0d cycles, the DUT stopped responding", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        input_valid = 1'b0;
        input_data = '0;
        new_matrix = 1'b0;
        output_ready = 1'b0;
        seed = 32'h1367_3187;
        checks = 0;
        errors = 0;
        tests = 0;
        test_start_errors = 0;
        taken_count = 0;
        cycles = 0;
        gap_max = 0;
        stall_max = 0;
        stall_left = 0;
        rest = 1'b0;
        hold_pending = 1'b0;
        held_data = '0;
        cycle_limit = 2 * (40 + 4 * frame_cycles(0, 0) + 5 * frame_cycles(1, 2)
                      + 8 * frame_cycles(0, 8) + 4 * frame_cycles(0, 3)
                      + 6 * frame_cycles(5, 3));

        repeat (10) @(negedge clk);
        reset = 1'b0;
        check_flag("input_ready after reset", input_ready, 1'b1);
        check_flag("output_valid after reset", output_valid, 1'b0);
        finish_test("reset state");

        repeat (4) run_frame(1'b1, K_RANDOM);
        finish_test("new matrix frames");

        gap_max = 1;
        stall_max = 2;
        repeat (5) run_frame(1'b0, K_RANDOM);
        finish_test("matrix reuse frames");

        gap_max = 0;
        stall_max = 8;
        repeat (8) run_frame(rand_below(2) == 1, K_RANDOM);
        finish_test("output back-pressure");

        stall_max = 3;
        run_frame(1'b1, K_MAX);
        run_frame(1'b1, K_MIN);
        run_frame(1'b1, K_MIXED);
        run_frame(1'b0, K_MAX);   // stored top matrix against a top vector
        finish_test("extreme values");

        gap_max = 5;
        repeat (6) run_frame(rand_below(2) == 1, K_RANDOM);
        finish_test("input gaps");

        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
